/* design/sim_cfg_pkg.sv */
`default_nettype none

package sim_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////
    // parameter word and host request
    ////////////////////////////////////////////////////////////////////////

    // width of one run-time parameter word
    localparam int WORD_W = 32;

    // one host transaction, fields stable while req is high
    typedef struct packed {
        logic              we;
        logic [7:0]        addr;
        logic [WORD_W-1:0] wdata;
    } host_req_t;

    ////////////////////////////////////////////////////////////////////////
    // parameter registers
    ////////////////////////////////////////////////////////////////////////

    // write addresses
    localparam logic [7:0] ADDR_HALF_CNT = 8'h00;
    localparam logic [7:0] ADDR_SYN_GAIN = 8'h06;
    localparam logic [7:0] ADDR_LEN_F0   = 8'h08;

    // reset values, len_f0 is 0.9 in single precision
    localparam logic        [WORD_W-1:0] RST_HALF_CNT = 32'd9;
    localparam logic signed [WORD_W-1:0] RST_SYN_GAIN = 32'sd1;
    localparam logic        [WORD_W-1:0] RST_LEN_F0   = 32'h3F66_6666;

    // half_cnt unsigned, syn_gain two's complement, len_f0 ieee single
    typedef struct packed {
        logic        [WORD_W-1:0] half_cnt;
        logic signed [WORD_W-1:0] syn_gain;
        logic        [WORD_W-1:0] len_f0;
    } sim_params_t;

endpackage

`default_nettype wire

/* design/sim_obs_pkg.sv */
`default_nettype none

package sim_obs_pkg;

    // host readout is done in 16-bit halves
    localparam int HALF_W = 16;

    // observed quantities
    // syn_current signed, counts unsigned, len_sample ieee single
    typedef struct packed {
        logic signed [31:0] syn_current;
        logic        [31:0] sn_count;
        logic        [31:0] mn_count;
        logic        [31:0] len_sample;
    } sim_obs_t;

    // length sample after reset, 1.0
    localparam logic [31:0] RST_LEN_SAMPLE = 32'h3F80_0000;

    ////////////////////////////////////////////////////////////////////////
    // readout addresses, lo then hi half
    ////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] ADDR_SYN_LO = 8'h20;
    localparam logic [7:0] ADDR_SYN_HI = 8'h21;
    localparam logic [7:0] ADDR_SN_LO  = 8'h24;
    localparam logic [7:0] ADDR_SN_HI  = 8'h25;
    localparam logic [7:0] ADDR_MN_LO  = 8'h26;
    localparam logic [7:0] ADDR_MN_HI  = 8'h27;
    localparam logic [7:0] ADDR_LEN_LO = 8'h28;
    localparam logic [7:0] ADDR_LEN_HI = 8'h29;

endpackage

`default_nettype wire

/* design/host_port_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module host_port_fsm (
    input  wire                                  ep50trig,
    input  wire                                  reset_sim,
    input  wire                                  i_req,
    input  wire sim_cfg_pkg::host_req_t          i_host,
    input  wire sim_obs_pkg::sim_obs_t           i_obs,
    output logic                                 o_ack,
    output logic                                 o_wr_stb,
    output logic [7:0]                           o_wr_addr,
    output logic [sim_cfg_pkg::WORD_W-1:0]       o_wr_data,
    output logic [sim_obs_pkg::HALF_W-1:0]       o_rd_data
);
    import sim_obs_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ACK, ST_RELEASE} state_t;

    state_t            state;
    logic              accept;
    logic [HALF_W-1:0] rd_sel;

    // new request only taken from idle
    assign accept = (state == ST_IDLE) && i_req;

    ////////////////////////////////////////////////////////////////////////
    // readout decode, unknown address reads as zero
    ////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (i_host.addr)
            ADDR_SYN_LO: rd_sel = i_obs.syn_current[HALF_W-1:0];
            ADDR_SYN_HI: rd_sel = i_obs.syn_current[2*HALF_W-1:HALF_W];
            ADDR_SN_LO:  rd_sel = i_obs.sn_count[HALF_W-1:0];
            ADDR_SN_HI:  rd_sel = i_obs.sn_count[2*HALF_W-1:HALF_W];
            ADDR_MN_LO:  rd_sel = i_obs.mn_count[HALF_W-1:0];
            ADDR_MN_HI:  rd_sel = i_obs.mn_count[2*HALF_W-1:HALF_W];
            ADDR_LEN_LO: rd_sel = i_obs.len_sample[HALF_W-1:0];
            ADDR_LEN_HI: rd_sel = i_obs.len_sample[2*HALF_W-1:HALF_W];
            default:     rd_sel = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // handshake: idle -> ack -> release -> idle
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            state     <= ST_IDLE;
            o_ack     <= 1'b0;
            o_wr_stb  <= 1'b0;
            o_rd_data <= '0;
        end
        else
        begin
            // strobe lives for the first ack cycle only
            o_wr_stb <= accept && i_host.we;
            case (state)
                ST_IDLE:
                begin
                    if (i_req)
                    begin
                        state <= ST_ACK;
                        o_ack <= 1'b1;
                        // readout frozen until next read
                        if (!i_host.we)
                            o_rd_data <= rd_sel;
                    end
                end
                ST_ACK:
                begin
                    // hold ack as long as host holds req
                    if (!i_req)
                    begin
                        state <= ST_RELEASE;
                        o_ack <= 1'b0;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // write fields captured with the request
    always_ff @(posedge ep50trig)
    begin
        if (accept)
        begin
            o_wr_addr <= i_host.addr;
            o_wr_data <= i_host.wdata;
        end
    end

endmodule

`default_nettype wire

/* design/param_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module param_bank (
    input  wire                                ep50trig,
    input  wire                                reset_sim,
    input  wire                                i_wr_stb,
    input  wire [7:0]                          i_wr_addr,
    input  wire [sim_cfg_pkg::WORD_W-1:0]      i_wr_data,
    output sim_cfg_pkg::sim_params_t           o_params
);
    import sim_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // run-time parameter registers
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            // tick half count, 9 gives a 20-cycle tick
            o_params.half_cnt <= RST_HALF_CNT;
            // unity synaptic gain
            o_params.syn_gain <= RST_SYN_GAIN;
            // muscle length register
            o_params.len_f0   <= RST_LEN_F0;
        end
        else if (i_wr_stb)
        begin
            // one register per address
            case (i_wr_addr)
                ADDR_HALF_CNT:
                    o_params.half_cnt <= i_wr_data;
                ADDR_SYN_GAIN:
                    o_params.syn_gain <= $signed(i_wr_data);
                ADDR_LEN_F0:
                    o_params.len_f0 <= i_wr_data;
                default:
                begin
                    // other addresses leave everything as is
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/sim_tick_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sim_tick_timer (
    input  wire                              ep50trig,
    input  wire                              reset_sim,
    input  wire [sim_cfg_pkg::WORD_W-1:0]    i_half_cnt,
    output logic                             o_tick
);
    import sim_cfg_pkg::*;

    logic [WORD_W-1:0] half_lat;
    logic [WORD_W-1:0] cnt;
    logic              phase;
    logic              wrap;

    // end of one half period
    assign wrap = (cnt == half_lat);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            half_lat <= RST_HALF_CNT;
            cnt      <= '0;
            phase    <= 1'b0;
            o_tick   <= 1'b0;
        end
        else
        begin
            // tick on second wrap of each period
            o_tick <= wrap && phase;
            if (wrap)
            begin
                cnt   <= '0;
                phase <= ~phase;
                // new half count only at period boundary
                if (phase)
                    half_lat <= i_half_cnt;
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/spike_window_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_window_counter (
    input  wire                                 ep50trig,
    input  wire                                 reset_sim,
    input  wire                                 i_spike,
    input  wire                                 i_tick,
    output logic [sim_cfg_pkg::WORD_W-1:0]      o_count
);
    import sim_cfg_pkg::*;

    logic              spike_d;
    logic              spike_rise;
    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] acc_next;

    ////////////////////////////////////////////////////////////////////////
    // rising edge detect
    ////////////////////////////////////////////////////////////////////////
    assign spike_rise = i_spike && !spike_d;

    // running total incl. this cycle's edge
    assign acc_next = acc + {{(WORD_W-1){1'b0}}, spike_rise};

    ////////////////////////////////////////////////////////////////////////
    // window accumulate and hand-off
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            spike_d <= 1'b0;
            acc     <= '0;
            o_count <= '0;
        end
        else
        begin
            spike_d <= i_spike;
            if (i_tick)
            begin
                // tick cycle still belongs to the closing window
                o_count <= acc_next;
                acc     <= '0;
            end
            else
                acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* design/sim_state_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module sim_state_sampler (
    input  wire                                   ep50trig,
    input  wire                                   reset_sim,
    input  wire                                   i_tick,
    input  wire signed [sim_cfg_pkg::WORD_W-1:0]  i_syn_raw,
    input  wire signed [sim_cfg_pkg::WORD_W-1:0]  i_syn_gain,
    input  wire        [sim_cfg_pkg::WORD_W-1:0]  i_len_f0,
    output logic signed [sim_cfg_pkg::WORD_W-1:0] o_syn_current,
    output logic        [sim_cfg_pkg::WORD_W-1:0] o_len_sample
);
    import sim_cfg_pkg::*;
    import sim_obs_pkg::*;

    logic signed [2*WORD_W-1:0] syn_prod;

    ////////////////////////////////////////////////////////////////////////
    // synaptic gain
    ////////////////////////////////////////////////////////////////////////

    // full signed product, low word kept
    assign syn_prod = i_syn_raw * i_syn_gain;

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_syn_current <= '0;
        else
            o_syn_current <= syn_prod[WORD_W-1:0];
    end

    ////////////////////////////////////////////////////////////////////////
    // muscle length, one sample per tick
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_len_sample <= RST_LEN_SAMPLE;
        else if (i_tick)
            o_len_sample <= i_len_f0;
    end

endmodule

`default_nettype wire

/* design/limb_sim_core.sv */
`timescale 1ns/1ps
`default_nettype none

module limb_sim_core (
    input  wire                                  ep50trig,
    input  wire                                  reset_sim,
    input  wire                                  i_req,
    input  wire sim_cfg_pkg::host_req_t          i_host,
    input  wire                                  i_sn_spike,
    input  wire                                  i_mn_spike,
    input  wire signed [sim_cfg_pkg::WORD_W-1:0] i_syn_raw,
    output logic                                 o_ack,
    output logic [sim_obs_pkg::HALF_W-1:0]       o_rd_data,
    output logic                                 o_tick
);
    import sim_cfg_pkg::*;
    import sim_obs_pkg::*;

    logic                      wr_stb;
    logic [7:0]                wr_addr;
    logic [WORD_W-1:0]         wr_data;
    sim_params_t               params;
    sim_obs_t                  obs;
    logic                      tick;
    logic [WORD_W-1:0]         sn_count;
    logic [WORD_W-1:0]         mn_count;
    logic signed [WORD_W-1:0]  syn_current;
    logic [WORD_W-1:0]         len_sample;

    ////////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////////
    host_port_fsm u_host_port_fsm (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_req     (i_req),
        .i_host    (i_host),
        .i_obs     (obs),
        .o_ack     (o_ack),
        .o_wr_stb  (wr_stb),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data),
        .o_rd_data (o_rd_data)
    );

    param_bank u_param_bank (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_wr_stb  (wr_stb),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_params  (params)
    );

    ////////////////////////////////////////////////////////////////////////
    // simulation side
    ////////////////////////////////////////////////////////////////////////
    sim_tick_timer u_sim_tick_timer (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_half_cnt (params.half_cnt),
        .o_tick     (tick)
    );

    // sensory pool
    spike_window_counter u_sn_counter (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_sn_spike),
        .i_tick    (tick),
        .o_count   (sn_count)
    );

    // motor pool
    spike_window_counter u_mn_counter (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_mn_spike),
        .i_tick    (tick),
        .o_count   (mn_count)
    );

    sim_state_sampler u_sim_state_sampler (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_tick        (tick),
        .i_syn_raw     (i_syn_raw),
        .i_syn_gain    (params.syn_gain),
        .i_len_f0      (params.len_f0),
        .o_syn_current (syn_current),
        .o_len_sample  (len_sample)
    );

    // observation record for readout
    assign obs = '{
        syn_current: syn_current,
        sn_count:    sn_count,
        mn_count:    mn_count,
        len_sample:  len_sample
    };

    assign o_tick = tick;

endmodule

`default_nettype wire

/* tests/tb_limb_sim_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_limb_sim_core;
    import sim_cfg_pkg::*;
    import sim_obs_pkg::*;

    localparam int ACK_TIMEOUT  = 16;
    localparam int TICK_TIMEOUT = 200;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDW, OP_TICK, OP_RAW, OP_SPK, OP_CNT} op_t;

    // op, address, write data or tick count, expected value or tick spacing
    typedef struct packed {
        op_t               op;
        logic [7:0]        addr;
        logic [WORD_W-1:0] data;
        logic [WORD_W-1:0] expd;
    } step_t;

    logic                     ep50trig;
    logic                     reset_sim;
    logic                     i_req;
    host_req_t                i_host;
    logic                     i_sn_spike;
    logic                     i_mn_spike;
    logic signed [WORD_W-1:0] i_syn_raw;
    logic                     o_ack;
    logic [HALF_W-1:0]        o_rd_data;
    logic                     o_tick;

    step_t             steps[$];
    step_t             st;
    logic [15:0]       lfsr;
    logic              spikes_on;
    logic [HALF_W-1:0] rd_half;
    logic [WORD_W-1:0] rd_word;
    logic [WORD_W-1:0] exp_sn;
    logic [WORD_W-1:0] exp_mn;
    int                value_errs;
    int                other_errs;
    // tick monitor state
    int                cyc_count;
    int                last_tick_cyc;
    int                last_spacing;
    int                tick_total;
    // window model of both pools
    logic              sn_prev;
    logic              mn_prev;
    logic [WORD_W-1:0] sn_acc;
    logic [WORD_W-1:0] mn_acc;
    logic [WORD_W-1:0] pred_sn;
    logic [WORD_W-1:0] pred_mn;

    limb_sim_core u_dut (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_req      (i_req),
        .i_host     (i_host),
        .i_sn_spike (i_sn_spike),
        .i_mn_spike (i_mn_spike),
        .i_syn_raw  (i_syn_raw),
        .o_ack      (o_ack),
        .o_rd_data  (o_rd_data),
        .o_tick     (o_tick)
    );

    // 4 ns clock
    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;
    end

    //////////////////////////////////////////////////////////////////////
    // reference models sampled at the falling edge
    //////////////////////////////////////////////////////////////////////

    // cycles since reset release
    always @(posedge ep50trig)
    begin
        if (reset_sim)
            cyc_count <= 0;
        else
            cyc_count <= cyc_count + 1;
    end

    always @(negedge ep50trig)
    begin
        if (reset_sim)
        begin
            last_tick_cyc = 0;
            last_spacing  = 0;
            tick_total    = 0;
            sn_prev       = 1'b0;
            mn_prev       = 1'b0;
            sn_acc        = '0;
            mn_acc        = '0;
            pred_sn       = '0;
            pred_mn       = '0;
        end
        else
        begin
            // edge in this cycle belongs to the open window
            if (i_sn_spike && !sn_prev)
                sn_acc = sn_acc + 1;
            if (i_mn_spike && !mn_prev)
                mn_acc = mn_acc + 1;
            sn_prev = i_sn_spike;
            mn_prev = i_mn_spike;
            // tick cycle closes the window
            if (o_tick)
            begin
                pred_sn       = sn_acc;
                pred_mn       = mn_acc;
                sn_acc        = '0;
                mn_acc        = '0;
                last_spacing  = cyc_count - last_tick_cyc;
                last_tick_cyc = cyc_count;
                tick_total    = tick_total + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // galois lfsr with taps at x^16 x^14 x^13 x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        else
            return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // inputs change 1 ns after each clock edge
    task automatic next_cycle();
        logic b;
        @(posedge ep50trig);
        #1;
        if (spikes_on)
        begin
            take_bit(b);
            i_sn_spike = b;
            take_bit(b);
            i_mn_spike = b;
        end
        else
        begin
            i_sn_spike = 1'b0;
            i_mn_spike = 1'b0;
        end
    endtask

    task automatic check_half(input string name, input logic [HALF_W-1:0] got,
                              input logic [HALF_W-1:0] expd);
        if (got !== expd)
        begin
            value_errs++;
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, expd);
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] expd);
        if (got !== expd)
        begin
            value_errs++;
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, expd);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expd);
        if (got != expd)
        begin
            value_errs++;
            $display("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, expd);
        end
    endtask

    // full four-phase transaction returning the read data
    task automatic host_xfer(input logic we, input logic [7:0] addr,
                             input logic [WORD_W-1:0] wdata,
                             output logic [HALF_W-1:0] rdata);
        int                n;
        logic [HALF_W-1:0] held;
        i_host = '{we: we, addr: addr, wdata: wdata};
        i_req  = 1'b1;
        rdata  = '0;
        n      = 0;
        while (!o_ack && n < ACK_TIMEOUT)
        begin
            next_cycle();
            n++;
        end
        if (!o_ack)
        begin
            other_errs++;
            $display("timeout: no ack within %0d cycles of req, t=%0t", ACK_TIMEOUT, $time);
            i_req = 1'b0;
            return;
        end
        check_count("ack_rise_latency", n, 1);
        held  = o_rd_data;
        rdata = o_rd_data;
        // ack and data must stay while req is held one extra cycle
        next_cycle();
        if (!o_ack)
        begin
            other_errs++;
            $display("ack dropped while req was still high, t=%0t", $time);
        end
        check_half("o_rd_data", o_rd_data, held);
        i_req = 1'b0;
        n     = 0;
        while (o_ack && n < ACK_TIMEOUT)
        begin
            check_half("o_rd_data", o_rd_data, held);
            next_cycle();
            n++;
        end
        if (o_ack)
        begin
            other_errs++;
            $display("timeout: ack still high %0d cycles after req fell, t=%0t",
                     ACK_TIMEOUT, $time);
        end
        else
            check_count("ack_fall_latency", n, 1);
        // release state before the next req
        next_cycle();
    endtask

    // lo half then hi half
    task automatic read_word(input logic [7:0] lo_addr, output logic [WORD_W-1:0] w);
        logic [HALF_W-1:0] lo;
        logic [HALF_W-1:0] hi;
        host_xfer(1'b0, lo_addr, '0, lo);
        host_xfer(1'b0, lo_addr + 8'd1, '0, hi);
        w = {hi, lo};
    endtask

    // spacing 0 skips the check
    task automatic wait_ticks(input int count, input int spacing);
        int target;
        int n;
        for (int k = 0; k < count; k++)
        begin
            target = tick_total + 1;
            n      = 0;
            while (tick_total < target && n < TICK_TIMEOUT)
            begin
                next_cycle();
                n++;
            end
            if (tick_total < target)
            begin
                other_errs++;
                $display("timeout: no tick within %0d cycles, t=%0t", TICK_TIMEOUT, $time);
            end
            else if (spacing != 0)
                check_count("tick_spacing", last_spacing, spacing);
        end
    endtask

    task automatic add_step(input op_t op, input logic [7:0] addr,
                            input logic [WORD_W-1:0] data, input logic [WORD_W-1:0] expd);
        steps.push_back('{op, addr, data, expd});
    endtask

    //////////////////////////////////////////////////////////////////////
    // operation table
    //////////////////////////////////////////////////////////////////////
    task automatic build_table();
        // reset values before the first tick and a zero read from an unknown address
        add_step(OP_RD,   ADDR_LEN_LO,   32'h0, 32'h0000);
        add_step(OP_RD,   ADDR_LEN_HI,   32'h0, 32'h3F80);
        add_step(OP_RD,   8'h40,         32'h0, 32'h0000);
        // first tick 20 cycles after release samples the length
        add_step(OP_TICK, 8'h00,         1,     20);
        add_step(OP_RDW,  ADDR_LEN_LO,   32'h0, 32'h3F66_6666);
        // running period finishes at 20 before the spacing drops to 10
        add_step(OP_WR,   ADDR_HALF_CNT, 4,     32'h0);
        add_step(OP_TICK, 8'h00,         1,     20);
        add_step(OP_TICK, 8'h00,         2,     10);
        // idle inputs read as zero
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'h0);
        add_step(OP_RDW,  ADDR_SN_LO,    32'h0, 32'h0);
        add_step(OP_RDW,  ADDR_MN_LO,    32'h0, 32'h0);
        // new length visible after next tick
        add_step(OP_TICK, 8'h00,         1,     10);
        add_step(OP_WR,   ADDR_LEN_F0,   32'h3F00_0000, 32'h0);
        add_step(OP_TICK, 8'h00,         1,     10);
        add_step(OP_RDW,  ADDR_LEN_LO,   32'h0, 32'h3F00_0000);
        // low word of gain times raw current
        add_step(OP_WR,   ADDR_SYN_GAIN, 32'h0000_0001, 32'h0);
        add_step(OP_RAW,  8'h00,         32'h0000_1234, 32'h0);
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'h0000_1234);
        add_step(OP_WR,   ADDR_SYN_GAIN, 32'hFFFF_FFFD, 32'h0);
        add_step(OP_RAW,  8'h00,         32'd1000, 32'h0);
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'hFFFF_F448);
        add_step(OP_WR,   ADDR_SYN_GAIN, 32'h0001_0000, 32'h0);
        add_step(OP_RAW,  8'h00,         32'h0001_2345, 32'h0);
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'h2345_0000);
        add_step(OP_RAW,  8'h00,         32'hFFFF_FFFB, 32'h0);
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'hFFFB_0000);
        // stray write leaves every readout alone across the next tick
        add_step(OP_WR,   8'h7F,         32'hDEAD_BEEF, 32'h0);
        add_step(OP_TICK, 8'h00,         1,     10);
        add_step(OP_RDW,  ADDR_SYN_LO,   32'h0, 32'hFFFB_0000);
        add_step(OP_RDW,  ADDR_LEN_LO,   32'h0, 32'h3F00_0000);
        add_step(OP_RD,   8'h40,         32'h0, 32'h0000);
        add_step(OP_TICK, 8'h00,         2,     10);
        // 40-cycle windows for spike counting
        add_step(OP_WR,   ADDR_HALF_CNT, 19,    32'h0);
        add_step(OP_TICK, 8'h00,         1,     10);
        add_step(OP_TICK, 8'h00,         1,     40);
        add_step(OP_SPK,  8'h00,         1,     32'h0);
        for (int k = 0; k < 5; k++)
        begin
            add_step(OP_TICK, 8'h00, 1, 40);
            add_step(OP_CNT,  8'h00, 32'h0, 32'h0);
        end
        // windows drain back to zero
        add_step(OP_SPK,  8'h00,         0,     32'h0);
        add_step(OP_TICK, 8'h00,         1,     40);
        add_step(OP_CNT,  8'h00,         32'h0, 32'h0);
        add_step(OP_TICK, 8'h00,         1,     40);
        add_step(OP_CNT,  8'h00,         32'h0, 32'h0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        reset_sim  = 1'b1;
        i_req      = 1'b0;
        i_host     = '0;
        i_sn_spike = 1'b0;
        i_mn_spike = 1'b0;
        i_syn_raw  = '0;
        spikes_on  = 1'b0;
        lfsr       = 16'd41192;
        value_errs = 0;
        other_errs = 0;
        build_table();
        repeat (10) next_cycle();
        reset_sim = 1'b0;

        foreach (steps[i])
        begin
            st = steps[i];
            case (st.op)
                OP_WR:
                    host_xfer(1'b1, st.addr, st.data, rd_half);
                OP_RD:
                begin
                    host_xfer(1'b0, st.addr, '0, rd_half);
                    check_half($sformatf("o_rd_data@%02h", st.addr), rd_half,
                               st.expd[HALF_W-1:0]);
                end
                OP_RDW:
                begin
                    read_word(st.addr, rd_word);
                    check_word($sformatf("word@%02h", st.addr), rd_word, st.expd);
                end
                OP_TICK:
                    wait_ticks(int'(st.data), int'(st.expd));
                OP_RAW:
                begin
                    // product registered one cycle later
                    i_syn_raw = st.data;
                    next_cycle();
                    next_cycle();
                end
                OP_SPK:
                    spikes_on = st.data[0];
                OP_CNT:
                begin
                    // window closed by the tick just waited for
                    exp_sn = pred_sn;
                    exp_mn = pred_mn;
                    read_word(ADDR_SN_LO, rd_word);
                    check_word("sn_count", rd_word, exp_sn);
                    read_word(ADDR_MN_LO, rd_word);
                    check_word("mn_count", rd_word, exp_mn);
                end
                default:
                begin
                    other_errs++;
                    $display("table entry %0d has an unknown operation", i);
                end
            endcase
        end

        $display("value errors: %0d, timeout/protocol errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/limb_sim_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module limb_sim_core_props (
    input wire ep50trig,
    input wire reset_sim,
    input wire i_req,
    input wire i_ack,
    input wire i_tick
);

    // ack only answers a request seen in the previous cycle
    ack_rise_on_req: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        $rose(i_ack) |-> $past(i_req)
    ) else $error("ack rose without a pending req");

    // ack released only once the host let go of req
    ack_fall_after_req: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        $fell(i_ack) |-> $past(!i_req)
    ) else $error("ack fell while req was still high");

    // tick is a single-cycle pulse
    tick_one_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        i_tick |=> !i_tick
    ) else $error("tick high for two cycles in a row");

endmodule

//////////////////////////////////////////////////////////////////////
// attach to handshake and tick sources
//////////////////////////////////////////////////////////////////////
bind host_port_fsm limb_sim_core_props u_hs_props (
    .ep50trig  (ep50trig),
    .reset_sim (reset_sim),
    .i_req     (i_req),
    .i_ack     (o_ack),
    .i_tick    (1'b0)
);

bind sim_tick_timer limb_sim_core_props u_tick_props (
    .ep50trig  (ep50trig),
    .reset_sim (reset_sim),
    .i_req     (1'b0),
    .i_ack     (1'b0),
    .i_tick    (o_tick)
);

`default_nettype wire

/* src.f */
design/sim_cfg_pkg.sv
design/sim_obs_pkg.sv
design/host_port_fsm.sv
design/param_bank.sv
design/sim_tick_timer.sv
design/spike_window_counter.sv
design/sim_state_sampler.sv
design/limb_sim_core.sv
tests/tb_limb_sim_core.sv
tests/limb_sim_core_props.sv

/* Makefile */
# Verilator flow for the limb simulation core
VERILATOR ?= verilator
TOP       ?= tb_limb_sim_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
